// File: rtl/eeprom_txn_pkg.sv
package eeprom_txn_pkg;

    typedef enum logic
    {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } eeprom_op_e;

    typedef enum logic
    {
        ST_OK   = 1'b0,
        ST_NACK = 1'b1   // slave refused a byte
    } rsp_status_e;

    localparam int ADDR_W = 11;   // 2 KB part, top 3 bits go in the control byte
    localparam int DATA_W = 8;

    localparam logic [3:0] DEV_CODE = 4'b1010;

    // queue depths double as the initial credit counts
    localparam int CMD_DEPTH = 2;
    localparam int RSP_DEPTH = 2;

    localparam int CMD_PTR_W = $clog2(CMD_DEPTH);
    localparam int CMD_CNT_W = $clog2(CMD_DEPTH + 1);
    localparam int RSP_PTR_W = $clog2(RSP_DEPTH);
    localparam int RSP_CNT_W = $clog2(RSP_DEPTH + 1);
    localparam int HOST_CREDIT_W = 4;   // host may hold up to 15 response slots

endpackage

// File: rtl/serial_bus_pkg.sv
package serial_bus_pkg;

    typedef enum logic [3:0]
    {
        IDLE,
        START,
        SEND_BYTE,
        GET_ACK,
        RESTART,
        RECV_BYTE,
        SEND_NOACK,
        STOP,
        DONE
    } bus_state_e;

    // scl level, one CLK per half cycle
    typedef enum logic
    {
        LOW  = 1'b0,
        HIGH = 1'b1
    } bus_phase_e;

endpackage

// File: rtl/eeprom_if.sv
interface eeprom_cmd_if
    import eeprom_txn_pkg::*;
();
    logic              valid;
    eeprom_op_e        op;
    logic [DATA_W-1:0] ctrl_byte;
    logic [DATA_W-1:0] addr_byte;
    logic [DATA_W-1:0] data;
    logic              take;   // pops the head entry

    modport source (output valid, op, ctrl_byte, addr_byte, data, input take);
    modport sink (input valid, op, ctrl_byte, addr_byte, data, output take);
endinterface

interface eeprom_rsp_if
    import eeprom_txn_pkg::*;
();
    logic              push;
    eeprom_op_e        op;
    rsp_status_e       status;
    logic [DATA_W-1:0] data;
    logic              credit;   // one slot freed in the response queue

    modport source (output push, op, status, data, input credit);
    modport sink (input push, op, status, data, output credit);
endinterface

// File: rtl/eeprom_cmd_decode.sv
module eeprom_cmd_decode
    import eeprom_txn_pkg::*;
(
    input  logic              CLK,
    input  logic              RESET,
    input  logic              cmd_valid,
    input  eeprom_op_e        cmd_op,
    input  logic [ADDR_W-1:0] cmd_addr,
    input  logic [DATA_W-1:0] cmd_data,
    output logic              cmd_credit,
    eeprom_cmd_if.source      cmd
);

    eeprom_op_e           q_op   [CMD_DEPTH];
    logic [DATA_W-1:0]    q_ctrl [CMD_DEPTH];
    logic [DATA_W-1:0]    q_addr [CMD_DEPTH];
    logic [DATA_W-1:0]    q_data [CMD_DEPTH];
    logic [CMD_PTR_W-1:0] wr_ptr;
    logic [CMD_PTR_W-1:0] rd_ptr;
    logic [CMD_CNT_W-1:0] count;

    always_ff @(posedge CLK)
    begin
        if (cmd_valid)
        begin
            q_op[wr_ptr]   <= cmd_op;
            // device code, block select, write
            q_ctrl[wr_ptr] <= {DEV_CODE, cmd_addr[ADDR_W-1:DATA_W], 1'b0};
            q_addr[wr_ptr] <= cmd_addr[DATA_W-1:0];
            q_data[wr_ptr] <= cmd_data;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            cmd_credit <= 1'b0;
        end
        else
        begin
            if (cmd_valid)
                wr_ptr <= (wr_ptr == CMD_PTR_W'(CMD_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (cmd.take)
                rd_ptr <= (rd_ptr == CMD_PTR_W'(CMD_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({cmd_valid, cmd.take})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            cmd_credit <= cmd.take;   // slot free again
        end
    end

    assign cmd.valid     = count != '0;
    assign cmd.op        = q_op[rd_ptr];
    assign cmd.ctrl_byte = q_ctrl[rd_ptr];
    assign cmd.addr_byte = q_addr[rd_ptr];
    assign cmd.data      = q_data[rd_ptr];

    // host must stay within its command credit
    assert property (@(posedge CLK) disable iff (RESET)
        !(cmd_valid && count == CMD_CNT_W'(CMD_DEPTH)))
        else $error("command pushed into a full queue");

endmodule

// File: rtl/eeprom_bus_execute.sv
module eeprom_bus_execute
    import eeprom_txn_pkg::*;
    import serial_bus_pkg::*;
(
    input  logic         CLK,
    input  logic         RESET,
    eeprom_cmd_if.sink   cmd,
    eeprom_rsp_if.source rsp,
    output logic         scl,
    output logic         sda_oe,   // 1 pulls sda low
    input  logic         sda_in
);

    bus_state_e           state;
    bus_phase_e           phase;
    logic [2:0]           bit_cnt;
    logic [1:0]           byte_idx;
    logic [DATA_W-1:0]    shreg;
    eeprom_op_e           op_q;
    logic [DATA_W-1:0]    ctrl_q;
    logic [DATA_W-1:0]    addr_q;
    logic [DATA_W-1:0]    wdata_q;
    logic [DATA_W-1:0]    rx_data;
    rsp_status_e          status_q;
    logic [RSP_CNT_W-1:0] credit_cnt;
    logic                 start_cmd;
    logic                 run;

    assign start_cmd = state == IDLE && cmd.valid && credit_cnt != '0;
    assign run       = state != IDLE && state != DONE;

    assign cmd.take   = start_cmd;
    assign rsp.push   = state == DONE;
    assign rsp.op     = op_q;
    assign rsp.status = status_q;
    assign rsp.data   = rx_data;

    // scl moves on the falling CLK edge, so sda updates land mid phase
    always_ff @(negedge CLK)
    begin
        if (RESET)
            phase <= LOW;
        else if (run && phase == LOW)
            phase <= HIGH;
        else
            phase <= LOW;
    end

    assign scl = phase == HIGH;

    always_ff @(posedge CLK)
    begin
        if (RESET)
            credit_cnt <= RSP_CNT_W'(RSP_DEPTH);
        else
            case ({start_cmd, rsp.credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= IDLE;
            sda_oe  <= 1'b0;
            bit_cnt <= 3'd7;   // wraps back to 7 after every byte
        end
        else
        begin
            case (state)
                IDLE:
                    if (start_cmd)
                    begin
                        op_q     <= cmd.op;
                        ctrl_q   <= cmd.ctrl_byte;
                        addr_q   <= cmd.addr_byte;
                        wdata_q  <= cmd.data;
                        shreg    <= cmd.ctrl_byte;
                        byte_idx <= 2'd0;
                        status_q <= ST_OK;
                        rx_data  <= '0;
                        state    <= START;
                    end
                START:
                    if (phase == HIGH)
                    begin
                        sda_oe <= 1'b1;   // sda falls with scl high
                        state  <= SEND_BYTE;
                    end
                SEND_BYTE:
                    if (phase == LOW)
                        sda_oe <= ~shreg[DATA_W-1];
                    else
                    begin
                        shreg   <= shreg << 1;
                        bit_cnt <= bit_cnt - 1'b1;
                        if (bit_cnt == 3'd0)
                            state <= GET_ACK;
                    end
                GET_ACK:
                    if (phase == LOW)
                        sda_oe <= 1'b0;   // hand the line to the slave
                    else if (sda_in)
                    begin
                        status_q <= ST_NACK;
                        state    <= STOP;
                    end
                    else
                    begin
                        byte_idx <= byte_idx + 1'b1;
                        case (byte_idx)
                            2'd0:
                            begin
                                shreg <= addr_q;
                                state <= SEND_BYTE;
                            end
                            2'd1:
                                if (op_q == OP_WRITE)
                                begin
                                    shreg <= wdata_q;
                                    state <= SEND_BYTE;
                                end
                                else
                                    state <= RESTART;
                            default:
                                state <= (op_q == OP_WRITE) ? STOP : RECV_BYTE;
                        endcase
                    end
                RESTART:
                    if (phase == LOW)
                        sda_oe <= 1'b0;
                    else
                    begin
                        sda_oe <= 1'b1;
                        shreg  <= {ctrl_q[DATA_W-1:1], 1'b1};   // read control byte
                        state  <= SEND_BYTE;
                    end
                RECV_BYTE:
                    if (phase == LOW)
                        sda_oe <= 1'b0;
                    else
                    begin
                        shreg   <= {shreg[DATA_W-2:0], sda_in};
                        bit_cnt <= bit_cnt - 1'b1;
                        if (bit_cnt == 3'd0)
                            state <= SEND_NOACK;
                    end
                SEND_NOACK:
                    if (phase == LOW)
                    begin
                        sda_oe  <= 1'b0;   // released line is the no-ack
                        rx_data <= shreg;
                    end
                    else
                        state <= STOP;
                STOP:
                    if (phase == LOW)
                        sda_oe <= 1'b1;
                    else
                    begin
                        sda_oe <= 1'b0;   // sda rises with scl high
                        state  <= DONE;
                    end
                DONE:
                    state <= IDLE;
                default:
                    state <= IDLE;
            endcase
        end
    end

    // result block returns no more credits than it was given
    assert property (@(posedge CLK) disable iff (RESET)
        credit_cnt <= RSP_CNT_W'(RSP_DEPTH))
        else $error("result credit count above queue depth");

    assert property (@(posedge CLK) disable iff (RESET)
        ($changed(sda_oe) && $past(phase) == HIGH)
            |-> $past(state) inside {START, RESTART, STOP})
        else $error("sda changed while scl high outside start or stop");

endmodule

// File: rtl/eeprom_result.sv
module eeprom_result
    import eeprom_txn_pkg::*;
(
    input  logic              CLK,
    input  logic              RESET,
    eeprom_rsp_if.sink        rsp,
    input  logic              rsp_credit,
    output logic              rsp_valid,
    output eeprom_op_e        rsp_op,
    output rsp_status_e       rsp_status,
    output logic [DATA_W-1:0] rsp_data
);

    eeprom_op_e               q_op     [RSP_DEPTH];
    rsp_status_e              q_status [RSP_DEPTH];
    logic [DATA_W-1:0]        q_data   [RSP_DEPTH];
    logic [RSP_PTR_W-1:0]     wr_ptr;
    logic [RSP_PTR_W-1:0]     rd_ptr;
    logic [RSP_CNT_W-1:0]     count;
    logic [HOST_CREDIT_W-1:0] host_cnt;
    logic                     send;

    assign send       = count != '0 && host_cnt != '0;
    assign rsp.credit = send;   // entry leaves, execute may start another

    always_ff @(posedge CLK)
    begin
        if (rsp.push)
        begin
            q_op[wr_ptr]     <= rsp.op;
            q_status[wr_ptr] <= rsp.status;
            q_data[wr_ptr]   <= (rsp.op == OP_WRITE) ? '0 : rsp.data;
        end
        if (send)
        begin
            rsp_op     <= q_op[rd_ptr];
            rsp_status <= q_status[rd_ptr];
            rsp_data   <= q_data[rd_ptr];
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            host_cnt  <= '0;
            rsp_valid <= 1'b0;
        end
        else
        begin
            if (rsp.push)
                wr_ptr <= (wr_ptr == RSP_PTR_W'(RSP_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (send)
                rd_ptr <= (rd_ptr == RSP_PTR_W'(RSP_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({rsp.push, send})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            case ({rsp_credit, send})
                2'b10:   host_cnt <= host_cnt + 1'b1;
                2'b01:   host_cnt <= host_cnt - 1'b1;
                default: host_cnt <= host_cnt;
            endcase
            rsp_valid <= send;
        end
    end

    // execute only starts a command while holding a slot here
    assert property (@(posedge CLK) disable iff (RESET)
        !(rsp.push && count == RSP_CNT_W'(RSP_DEPTH)))
        else $error("result pushed into a full queue");

endmodule

// File: rtl/eeprom_ctrl_top.sv
module eeprom_ctrl_top
    import eeprom_txn_pkg::*;
(
    input  logic              CLK,
    input  logic              RESET,
    input  logic              cmd_valid,
    input  eeprom_op_e        cmd_op,
    input  logic [ADDR_W-1:0] cmd_addr,
    input  logic [DATA_W-1:0] cmd_data,
    output logic              cmd_credit,
    input  logic              rsp_credit,
    output logic              rsp_valid,
    output eeprom_op_e        rsp_op,
    output rsp_status_e       rsp_status,
    output logic [DATA_W-1:0] rsp_data,
    output logic              scl,
    output logic              sda_oe,
    input  logic              sda_in
);

    eeprom_cmd_if cmd_bus ();
    eeprom_rsp_if rsp_bus ();

    eeprom_cmd_decode u_decode (
        .CLK        (CLK),
        .RESET      (RESET),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_addr   (cmd_addr),
        .cmd_data   (cmd_data),
        .cmd_credit (cmd_credit),
        .cmd        (cmd_bus.source)
    );

    eeprom_bus_execute u_execute (
        .CLK    (CLK),
        .RESET  (RESET),
        .cmd    (cmd_bus.sink),
        .rsp    (rsp_bus.source),
        .scl    (scl),
        .sda_oe (sda_oe),
        .sda_in (sda_in)
    );

    eeprom_result u_result (
        .CLK        (CLK),
        .RESET      (RESET),
        .rsp        (rsp_bus.sink),
        .rsp_credit (rsp_credit),
        .rsp_valid  (rsp_valid),
        .rsp_op     (rsp_op),
        .rsp_status (rsp_status),
        .rsp_data   (rsp_data)
    );

endmodule

// File: tb/eeprom_slave_model.sv
module eeprom_slave_model
    import eeprom_txn_pkg::*;
(
    input  logic scl,
    input  logic sda,        // wired line
    input  logic nack,       // refuse the control byte of this transfer
    output logic sda_pull    // 1 pulls sda low
);

    typedef enum int {S_IDLE, S_RX, S_ACK, S_TX, S_MACK} slave_mode_e;

    logic [DATA_W-1:0] mem [1 << ADDR_W];
    slave_mode_e       mode;
    int                cnt;
    int                byte_no;
    logic              rd_mode;
    logic [2:0]        block;
    logic [DATA_W-1:0] word_addr;
    logic [DATA_W-1:0] sreg;
    logic [DATA_W-1:0] txbyte;

    initial
    begin
        for (int a = 0; a < (1 << ADDR_W); a++)
            mem[a] = a[7:0] ^ 8'h5A ^ {a[10:8], 5'b00000};
        mode     = S_IDLE;
        sda_pull = 1'b0;
        cnt      = 0;
        byte_no  = 0;
        rd_mode  = 1'b0;
        block    = '0;
        sreg     = '0;
    end

    task automatic take_byte();
        if (byte_no == 0 && (nack || sreg[7:4] != DEV_CODE))
        begin
            mode     = S_IDLE;   // no ack, wait for stop
            sda_pull = 1'b0;
        end
        else
        begin
            if (byte_no == 0)
            begin
                block   = sreg[3:1];
                rd_mode = sreg[0];
            end
            else if (byte_no == 1)
                word_addr = sreg;
            else
                mem[{block, word_addr}] = sreg;
            sda_pull = 1'b1;
            mode     = S_ACK;
        end
    endtask

    // start or repeated start
    always @(negedge sda)
        if (scl)
        begin
            mode     = S_RX;
            cnt      = 0;
            byte_no  = 0;
            rd_mode  = 1'b0;
            sda_pull = 1'b0;
        end

    always @(posedge sda)
        if (scl)
        begin
            mode     = S_IDLE;   // stop
            sda_pull = 1'b0;
        end

    always @(posedge scl)
        if (mode == S_RX)
        begin
            sreg = {sreg[DATA_W-2:0], sda};
            cnt++;
        end
        else if (mode == S_TX)
            cnt++;

    always @(negedge scl)
        case (mode)
            S_RX:
                if (cnt == 8)
                    take_byte();
            S_ACK:
            begin
                cnt = 0;
                if (rd_mode)
                begin
                    txbyte   = mem[{block, word_addr}];
                    sda_pull = ~txbyte[7];
                    mode     = S_TX;
                end
                else
                begin
                    sda_pull = 1'b0;
                    byte_no++;
                    mode = S_RX;
                end
            end
            S_TX:
                if (cnt == 8)
                begin
                    sda_pull = 1'b0;   // master gives the no-ack
                    mode     = S_MACK;
                end
                else
                    sda_pull = ~txbyte[7-cnt];
            S_MACK:
                mode = S_IDLE;
            default:
                mode = mode;
        endcase

endmodule

// File: tb/tb_eeprom_ctrl.sv
module tb_eeprom_ctrl;
    import eeprom_txn_pkg::*;

    localparam int NUM_CMDS     = 16;
    localparam int PHASE1_CMDS  = 9;
    localparam int FIELDS       = 6;
    localparam int WAIT_LIMIT   = 2000;   // cycles
    localparam int STALL_CYCLES = 400;
    localparam int HOST_SLOTS   = 2;

    logic              CLK;
    logic              RESET;
    logic              cmd_valid;
    eeprom_op_e        cmd_op;
    logic [ADDR_W-1:0] cmd_addr;
    logic [DATA_W-1:0] cmd_data;
    logic              cmd_credit;
    logic              rsp_credit;
    logic              rsp_valid;
    eeprom_op_e        rsp_op;
    rsp_status_e       rsp_status;
    logic [DATA_W-1:0] rsp_data;
    logic              scl;
    logic              sda_oe;
    logic              sda_line;
    logic              slave_pull;
    logic              slave_nack;

    logic [11:0] stim [FIELDS*NUM_CMDS];
    logic        nack_flags [64];   // one per bus transfer
    int          nack_wr;
    int          nack_rd;

    eeprom_op_e        exp_op_q [$];
    rsp_status_e       exp_status_q [$];
    logic [DATA_W-1:0] exp_data_q [$];

    int   cmd_credits;
    int   issued;
    int   received;
    int   granted_out;   // host credits held by the controller
    int   pending_grants;
    int   grant_gap;
    logic hold_rsp;
    logic stalled;

    assign sda_line   = !(sda_oe || slave_pull);
    assign slave_nack = nack_flags[nack_rd[5:0]];

    eeprom_ctrl_top DUT (
        .CLK        (CLK),
        .RESET      (RESET),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_addr   (cmd_addr),
        .cmd_data   (cmd_data),
        .cmd_credit (cmd_credit),
        .rsp_credit (rsp_credit),
        .rsp_valid  (rsp_valid),
        .rsp_op     (rsp_op),
        .rsp_status (rsp_status),
        .rsp_data   (rsp_data),
        .scl        (scl),
        .sda_oe     (sda_oe),
        .sda_in     (sda_line)
    );

    eeprom_slave_model u_slave (
        .scl      (scl),
        .sda      (sda_line),
        .nack     (slave_nack),
        .sda_pull (slave_pull)
    );

    initial
    begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_status(input rsp_status_e got, input rsp_status_e exp, input string what);
        if (got !== exp)
        begin
            fail_now($sformatf("Mismatch at %0t: %s got %s expected %s",
                $time, what, got.name(), exp.name()));
        end
    endtask

    task automatic check_op(input eeprom_op_e got, input eeprom_op_e exp, input string what);
        if (got !== exp)
        begin
            fail_now($sformatf("Mismatch at %0t: %s got %s expected %s",
                $time, what, got.name(), exp.name()));
        end
    endtask

    task automatic check_data(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                              input string what);
        if (got !== exp)
        begin
            fail_now($sformatf("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            fail_now($sformatf("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp)
        begin
            fail_now($sformatf("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic wait_cmd_credit();
        int n;
        n = 0;
        while (cmd_credits == 0)
        begin
            @(negedge CLK);
            n++;
            if (n > WAIT_LIMIT)
                fail_now("timed out waiting for a command credit");
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (received < issued)
        begin
            @(negedge CLK);
            n++;
            if (n > WAIT_LIMIT)
                fail_now("timed out waiting for outstanding responses");
        end
    endtask

    // true once cmd_credit has stayed away for the whole window
    task automatic watch_for_stall(output logic seen);
        int n;
        n    = 0;
        seen = 1'b0;
        while (cmd_credits == 0 && !seen)
        begin
            @(negedge CLK);
            n++;
            if (n >= STALL_CYCLES)
                seen = 1'b1;
        end
    endtask

    task automatic issue_cmd(input int idx);
        int base;
        base = idx * FIELDS;
        @(negedge CLK);
        repeat ($urandom_range(0, 3)) @(negedge CLK);
        wait_cmd_credit();
        cmd_valid = 1'b1;
        cmd_op    = eeprom_op_e'(stim[base][0]);
        cmd_addr  = stim[base+1][ADDR_W-1:0];
        cmd_data  = stim[base+2][DATA_W-1:0];
        nack_flags[nack_wr[5:0]] = stim[base+3][0];
        nack_wr++;
        exp_op_q.push_back(eeprom_op_e'(stim[base][0]));
        exp_status_q.push_back(rsp_status_e'(stim[base+4][0]));
        exp_data_q.push_back(stim[base+5][DATA_W-1:0]);
        cmd_credits--;
        issued++;
        @(negedge CLK);
        cmd_valid = 1'b0;
    endtask

    // stop condition ends a transfer
    always @(posedge sda_line)
        if (scl)
            nack_rd++;

    always @(posedge CLK)
        if (!RESET && cmd_credit)
        begin
            cmd_credits++;
            if (cmd_credits > CMD_DEPTH)
                fail_now("host command credit went above the queue depth");
        end

    always @(posedge CLK)
        if (!RESET && rsp_valid)
        begin
            if (exp_op_q.size() == 0)
                fail_now("response arrived with no command outstanding");
            if (granted_out == 0)
                fail_now("response sent without a host credit");
            check_op(rsp_op, exp_op_q.pop_front(), "rsp_op");
            check_status(rsp_status, exp_status_q.pop_front(), "rsp_status");
            check_data(rsp_data, exp_data_q.pop_front(), "rsp_data");
            received++;
            granted_out--;
            pending_grants++;
        end

    initial
    begin
        rsp_credit = 1'b0;
        forever
        begin
            @(negedge CLK);
            if (!RESET && !hold_rsp && pending_grants > 0 && grant_gap == 0)
            begin
                rsp_credit = 1'b1;
                pending_grants--;
                granted_out++;
                grant_gap = $urandom_range(0, 4);
            end
            else
            begin
                rsp_credit = 1'b0;
                if (grant_gap > 0)
                    grant_gap--;
            end
        end
    end

    initial
    begin
        void'($urandom(39664));
        RESET          = 1'b1;
        cmd_valid      = 1'b0;
        cmd_op         = OP_WRITE;
        cmd_addr       = '0;
        cmd_data       = '0;
        hold_rsp       = 1'b0;
        stalled        = 1'b0;
        cmd_credits    = CMD_DEPTH;
        issued         = 0;
        received       = 0;
        granted_out    = 0;
        pending_grants = HOST_SLOTS;
        grant_gap      = 0;
        nack_wr        = 0;
        nack_rd        = 0;
        for (int i = 0; i < 64; i++)
            nack_flags[i] = 1'b0;
        for (int i = 0; i < FIELDS*NUM_CMDS; i++)
            stim[i] = 12'hFFF;
        $readmemh("tb/eeprom_stimulus.txt", stim);
        if (stim[FIELDS*NUM_CMDS-1] == 12'hFFF)
            fail_now("stimulus file is missing or too short");

        repeat (2) @(negedge CLK);
        RESET = 1'b0;
        @(negedge CLK);
        check_bit(cmd_credit, 1'b0, "cmd_credit after reset");
        check_bit(rsp_valid, 1'b0, "rsp_valid after reset");
        check_bit(scl, 1'b0, "scl after reset");
        check_bit(sda_oe, 1'b0, "sda_oe after reset");

        for (int i = 0; i < PHASE1_CMDS; i++)
            issue_cmd(i);
        wait_drain();

        // hold response credits until the command path stalls
        hold_rsp = 1'b1;
        for (int i = PHASE1_CMDS; i < NUM_CMDS; i++)
        begin
            if (!stalled && cmd_credits == 0)
            begin
                watch_for_stall(stalled);
                if (stalled)
                begin
                    check_count(issued - received, CMD_DEPTH + RSP_DEPTH,
                        "outstanding commands at stall");
                    hold_rsp = 1'b0;
                end
            end
            issue_cmd(i);
        end
        if (!stalled)
            fail_now("command path never stalled under response back-pressure");
        wait_drain();

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: tb/eeprom_stimulus.txt
// op addr wdata nack status rdata, all hex
// op 0 write 1 read, nack 1 makes the slave refuse the control byte
0 010 A5 0 0 00
1 010 00 0 0 A5
1 123 00 0 0 59
1 7FF 00 0 0 45
0 200 3C 1 1 00
1 200 00 0 0 1A
1 055 00 1 1 00
0 300 11 0 0 00
0 301 22 0 0 00
0 302 33 0 0 00
1 300 00 0 0 11
1 301 00 0 0 22
1 302 00 0 0 33
0 4AB C7 0 0 00
1 4AB 00 0 0 C7
1 0AB 00 0 0 F1

// File: vlog.f
rtl/eeprom_txn_pkg.sv
rtl/serial_bus_pkg.sv
rtl/eeprom_if.sv
rtl/eeprom_cmd_decode.sv
rtl/eeprom_bus_execute.sv
rtl/eeprom_result.sv
rtl/eeprom_ctrl_top.sv
tb/eeprom_slave_model.sv
tb/tb_eeprom_ctrl.sv

// File: Makefile
.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f vlog.f --top-module tb_eeprom_ctrl -Mdir obj_dir
	./obj_dir/Vtb_eeprom_ctrl | awk '{ print } /TESTS PASSED/ { ok = 1 } END { exit !ok }'

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module tb_eeprom_ctrl

clean:
	rm -rf obj_dir
